/* vz_io.f */
rtl/vz_bus_pkg.sv
rtl/vz_kbd_pkg.sv
rtl/vz_cpu_cycle.sv
rtl/vz_key_matrix.sv
rtl/vz_io_decode.sv
rtl/vz_read_mux.sv
rtl/vz_io_top.sv
bench/vz_clk_gen.sv
bench/vz_io_tb.sv

/* bench/vz_io_tb.sv */
`timescale 1ns/10ps

module vz_io_tb;

	localparam int N_WR   = 8;
	localparam int N_SHRG = 4;
	localparam int N_KEY  = 24;
	localparam int N_KEYS = 16;
	localparam int N_EX   = 9;
	localparam int N_JOY  = 8;
	// Each bus cycle waits at most one CPU cycle for its start
	localparam int PLANNED_CYCLES = 2 * (3*N_WR + 3*N_SHRG + N_KEY + 2*N_EX + 1 + 3*N_JOY) + 32;
	localparam int WATCHDOG_NS    = 2 * PLANNED_CYCLES * 14 * 20;   // twice the worst case

	logic        CLK50MHZ, RESET_N;
	logic        turbo_i, shrg_en_i;
	logic [15:0] bus_addr_i;
	logic [7:0]  bus_data_i;
	logic        bus_mreq_i, bus_iorq_i, bus_rd_i, bus_wr_i;
	logic        key_strobe_i, key_pressed_i, key_extended_i;
	logic [7:0]  key_code_i;
	logic        cass_in_i;
	logic        joy_up_i, joy_down_i, joy_left_i, joy_right_i, joy_fire_i, joy_arm_i;
	logic        cpu_clk_o;
	logic [7:0]  read_data_o;
	logic [1:0]  speaker_o;
	logic        cass_out_o, vdg_ag_o, vdg_css_o;
	logic [2:0]  vdg_gm_o;

	int                    value_errors = 0;
	int                    other_errors = 0;
	logic [31:0]           lfsr = 32'h25e2_49d8;
	vz_bus_pkg::io_latch_u exp_latch;
	logic [63:0]           key_down;   // Model state, 1 = pressed
	logic [9:0]            ex_down;

	// Keys used for random presses, one per row and column at least
	logic [7:0] key_sc [N_KEYS] = '{vz_kbd_pkg::SC_T, vz_kbd_pkg::SC_E, vz_kbd_pkg::SC_Q,
		vz_kbd_pkg::SC_R, vz_kbd_pkg::SC_S, vz_kbd_pkg::SC_CTRL, vz_kbd_pkg::SC_LSHIFT,
		vz_kbd_pkg::SC_X, vz_kbd_pkg::SC_1, vz_kbd_pkg::SC_PERIOD, vz_kbd_pkg::SC_SPACE,
		vz_kbd_pkg::SC_M, vz_kbd_pkg::SC_9, vz_kbd_pkg::SC_MINUS, vz_kbd_pkg::SC_RETURN,
		vz_kbd_pkg::SC_H};
	int key_pos [N_KEYS] = '{vz_kbd_pkg::KEY_POS_T, vz_kbd_pkg::KEY_POS_E, vz_kbd_pkg::KEY_POS_Q,
		vz_kbd_pkg::KEY_POS_R, vz_kbd_pkg::KEY_POS_S, vz_kbd_pkg::KEY_POS_CTRL,
		vz_kbd_pkg::KEY_POS_LSHIFT, vz_kbd_pkg::KEY_POS_X, vz_kbd_pkg::KEY_POS_1,
		vz_kbd_pkg::KEY_POS_PERIOD, vz_kbd_pkg::KEY_POS_SPACE, vz_kbd_pkg::KEY_POS_M,
		vz_kbd_pkg::KEY_POS_9, vz_kbd_pkg::KEY_POS_MINUS, vz_kbd_pkg::KEY_POS_RETURN,
		vz_kbd_pkg::KEY_POS_H};
	// Indexed by extension position
	logic [7:0] ex_sc [N_EX] = '{vz_kbd_pkg::SC_RSHIFT, vz_kbd_pkg::SC_EXT_ALT,
		vz_kbd_pkg::SC_EXT_ALT, vz_kbd_pkg::SC_ESC, vz_kbd_pkg::SC_UP, vz_kbd_pkg::SC_LEFT,
		vz_kbd_pkg::SC_RIGHT, vz_kbd_pkg::SC_DOWN, vz_kbd_pkg::SC_BACKSPACE};
	logic [N_EX-1:0] ex_ext = 9'b0_1111_0100;   // LF and arrows carry the E0 prefix

	vz_clk_gen u_clk_gen
	(
		.clk_o   (CLK50MHZ),
		.rst_n_o (RESET_N)
	);

	vz_io_top dut_i (.*);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			val  = {val[30:0], lfsr[31]};
			lfsr = {lfsr[30:0], fb};
		end
		return val;
	endfunction

	// Column byte for the selected rows, extension keys folded in
	function automatic logic [7:0] keyboard_byte(input logic [7:0] rows, input logic cass);
		logic [63:0] down;
		logic [7:0]  val;
		down = key_down;
		down[vz_kbd_pkg::KEY_POS_PERIOD] |= ex_down[vz_kbd_pkg::EX_UP];
		down[vz_kbd_pkg::KEY_POS_M]      |= ex_down[vz_kbd_pkg::EX_LEFT] |
			ex_down[vz_kbd_pkg::EX_BACKSPACE];
		down[vz_kbd_pkg::KEY_POS_COMMA]  |= ex_down[vz_kbd_pkg::EX_RIGHT];
		down[vz_kbd_pkg::KEY_POS_SPACE]  |= ex_down[vz_kbd_pkg::EX_DOWN];
		down[vz_kbd_pkg::KEY_POS_MINUS]  |= ex_down[vz_kbd_pkg::EX_ESC];
		down[vz_kbd_pkg::KEY_POS_LSHIFT] |= ex_down[vz_kbd_pkg::EX_RSHIFT];
		down[vz_kbd_pkg::KEY_POS_CTRL]   |= ex_down[vz_kbd_pkg::EX_UP] |
			ex_down[vz_kbd_pkg::EX_LEFT] | ex_down[vz_kbd_pkg::EX_RIGHT] |
			ex_down[vz_kbd_pkg::EX_DOWN] | ex_down[vz_kbd_pkg::EX_ESC] |
			ex_down[vz_kbd_pkg::EX_BACKSPACE];
		val = {1'b1, ~cass, 6'b11_1111};
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 6; c++)
				if (!rows[r] && down[r*8+c])
					val[c] = 1'b0;
		return val;
	endfunction

	task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp)
		else
		begin
			value_errors++;
			$display("Fail %s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic verify_latch_outputs();
		expect_value("speaker_o", {exp_latch.bits.speaker_b, exp_latch.bits.speaker_a}, speaker_o);
		expect_value("cass_out_o", exp_latch.bits.cass_out, cass_out_o);
		expect_value("vdg_ag_o", exp_latch.bits.vdg_ag, vdg_ag_o);
		expect_value("vdg_css_o", exp_latch.bits.vdg_css, vdg_css_o);
	endtask

	task automatic wait_cpu_pulse();
		do
			@(negedge CLK50MHZ);
		while (!cpu_clk_o);
	endtask

	task automatic measure_period(output logic [7:0] clocks);
		wait_cpu_pulse();
		clocks = 0;
		do
		begin
			@(negedge CLK50MHZ);
			clocks++;
		end
		while (!cpu_clk_o && clocks < 32);
	endtask

	// Bus held from the latch strobe until the cycle after it
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic is_io,
		input logic is_wr, output logic [7:0] rdata);
		wait_cpu_pulse();
		@(posedge CLK50MHZ);
		bus_addr_i <= addr;
		bus_data_i <= data;
		bus_mreq_i <= !is_io;
		bus_iorq_i <= is_io;
		bus_rd_i   <= !is_wr;
		bus_wr_i   <= is_wr;
		@(posedge CLK50MHZ);   // latch edge
		@(negedge CLK50MHZ);
		rdata = read_data_o;
		@(posedge CLK50MHZ);
		bus_mreq_i <= 1'b0;
		bus_iorq_i <= 1'b0;
		bus_rd_i   <= 1'b0;
		bus_wr_i   <= 1'b0;
		@(negedge CLK50MHZ);
	endtask

	task automatic key_event(input logic [7:0] code, input logic ext, input logic press);
		@(posedge CLK50MHZ);
		key_strobe_i   <= 1'b1;
		key_code_i     <= code;
		key_extended_i <= ext;
		key_pressed_i  <= press;
		@(posedge CLK50MHZ);
		key_strobe_i <= 1'b0;
	endtask

	task automatic read_keys(input logic [7:0] rows);
		logic       cass;
		logic [7:0] rdata;
		cass = take_bits(1);
		@(posedge CLK50MHZ);
		cass_in_i <= cass;
		bus_cycle({8'h68, rows}, 8'h00, 1'b0, 1'b0, rdata);
		expect_value("read_data_o", keyboard_byte(rows, cass), rdata);
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		logic [7:0]  rdata;
		logic [7:0]  d;
		logic [7:0]  hi;
		logic [15:0] a;
		logic [5:0]  j;
		logic [3:0]  k;
		logic [2:0]  exp_gm;
		logic        press;
		logic [7:0]  clocks;

		turbo_i        = 1'b0;
		shrg_en_i      = 1'b0;
		bus_addr_i     = '0;
		bus_data_i     = '0;
		bus_mreq_i     = 1'b0;
		bus_iorq_i     = 1'b0;
		bus_rd_i       = 1'b0;
		bus_wr_i       = 1'b0;
		key_strobe_i   = 1'b0;
		key_pressed_i  = 1'b0;
		key_extended_i = 1'b0;
		key_code_i     = '0;
		cass_in_i      = 1'b0;
		{joy_arm_i, joy_fire_i, joy_right_i, joy_left_i, joy_down_i, joy_up_i} = '0;
		exp_latch.raw = '0;
		exp_gm        = 3'b010;
		key_down      = '0;
		ex_down       = '0;

		@(negedge CLK50MHZ);
		while (!RESET_N)
		begin
			assert (!cpu_clk_o)
			else
			begin
				other_errors++;
				$display("cpu_clk_o pulsed while RESET_N was low");
			end
			@(negedge CLK50MHZ);
		end
		expect_value("read_data_o", 8'hFF, read_data_o);
		verify_latch_outputs();
		expect_value("vdg_gm_o", exp_gm, vdg_gm_o);
		measure_period(clocks);
		expect_value("cpu_clk_o period", 8'd14, clocks);

		// Region writes load the latch, other writes must miss it
		for (int n = 0; n < N_WR; n++)
		begin
			d = take_bits(8);
			a = take_bits(16);
			a[15:11] = vz_bus_pkg::IO_REGION_TAG;
			bus_cycle(a, d, 1'b0, 1'b1, rdata);
			exp_latch.raw = d;
			verify_latch_outputs();
			a = take_bits(16);
			if (a[15:11] == vz_bus_pkg::IO_REGION_TAG)
				a[15] = 1'b1;
			bus_cycle(a, ~d, 1'b0, 1'b1, rdata);
			verify_latch_outputs();
			bus_cycle({vz_bus_pkg::IO_REGION_TAG, a[10:0]}, ~d, 1'b1, 1'b1, rdata);
			verify_latch_outputs();
		end

		expect_value("vdg_gm_o", exp_gm, vdg_gm_o);
		for (int n = 0; n < N_SHRG; n++)
		begin
			d  = take_bits(8);
			hi = take_bits(8);
			if (d[4:2] == exp_gm)
				d[4:2] = ~exp_gm;   // New mode always differs from the current one
			@(posedge CLK50MHZ);
			shrg_en_i <= 1'b0;
			bus_cycle({hi, vz_bus_pkg::PORT_SHRG}, d, 1'b1, 1'b1, rdata);
			expect_value("vdg_gm_o", exp_gm, vdg_gm_o);
			@(posedge CLK50MHZ);
			shrg_en_i <= 1'b1;
			bus_cycle({hi, vz_bus_pkg::PORT_SHRG}, d, 1'b1, 1'b1, rdata);
			exp_gm = d[4:2];
			expect_value("vdg_gm_o", exp_gm, vdg_gm_o);
			bus_cycle({8'h00, vz_bus_pkg::PORT_SHRG}, ~d, 1'b0, 1'b1, rdata);   // memory, not I/O
			expect_value("vdg_gm_o", exp_gm, vdg_gm_o);
		end

		for (int n = 0; n < N_KEY; n++)
		begin
			k     = take_bits(4);
			press = take_bits(1);
			key_event(key_sc[k], 1'b0, press);
			key_down[key_pos[k]] = press;
			read_keys(take_bits(8));
		end

		for (int i = 0; i < N_KEYS; i++)
		begin
			key_event(key_sc[i], 1'b0, 1'b0);
			key_down[key_pos[i]] = 1'b0;
		end
		for (int i = 0; i < N_EX; i++)
		begin
			key_event(ex_sc[i], ex_ext[i], 1'b1);
			ex_down[i] = 1'b1;
			read_keys(8'h00);
			read_keys(take_bits(8));
			key_event(ex_sc[i], ex_ext[i], 1'b0);
			ex_down[i] = 1'b0;
		end
		key_event(8'h05, 1'b0, 1'b1);   // F1 has no VZ key
		read_keys(8'h00);

		@(posedge CLK50MHZ);
		turbo_i <= 1'b1;
		wait_cpu_pulse();
		measure_period(clocks);
		expect_value("cpu_clk_o period", 8'd4, clocks);

		for (int n = 0; n < N_JOY; n++)
		begin
			j  = take_bits(6);
			hi = take_bits(8);
			@(posedge CLK50MHZ);
			{joy_arm_i, joy_fire_i, joy_right_i, joy_left_i, joy_down_i, joy_up_i} <= j;
			bus_cycle({hi, vz_bus_pkg::PORT_JOY1_A}, 8'h00, 1'b1, 1'b0, rdata);
			expect_value("read_data_o", {3'b111, ~j[4:0]}, rdata);
			bus_cycle({hi, vz_bus_pkg::PORT_JOY1_B}, 8'h00, 1'b1, 1'b0, rdata);
			expect_value("read_data_o", {3'b111, ~j[5], 4'hF}, rdata);
			d = take_bits(8);
			if (d == vz_bus_pkg::PORT_JOY1_A || d == vz_bus_pkg::PORT_JOY1_B)
				d = 8'h00;
			bus_cycle({hi, d}, 8'h00, 1'b1, 1'b0, rdata);   // Unused port floats high
			expect_value("read_data_o", 8'hFF, rdata);
		end

		$display("Errors: %0d wrong values, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* bench/vz_clk_gen.sv */
`timescale 1ns/10ps

module vz_clk_gen
(
	output logic clk_o,
	output logic rst_n_o
);

	localparam int RESET_CYCLES = 16;

	initial
	begin
		clk_o = 1'b0;
		forever
			#10 clk_o = ~clk_o;   // 20 ns period
	end

	// Release away from the rising edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o <= 1'b1;
	end

endmodule

/* rtl/vz_io_top.sv */
`timescale 1ns/10ps

module vz_io_top
(
	input  logic                          CLK50MHZ,
	input  logic                          RESET_N,
	input  logic                          turbo_i,
	input  logic                          shrg_en_i,
	input  logic [vz_bus_pkg::ADDR_W-1:0] bus_addr_i,
	input  logic [vz_bus_pkg::DATA_W-1:0] bus_data_i,
	input  logic                          bus_mreq_i,
	input  logic                          bus_iorq_i,
	input  logic                          bus_rd_i,
	input  logic                          bus_wr_i,
	input  logic                          key_strobe_i,
	input  logic                          key_pressed_i,
	input  logic                          key_extended_i,
	input  logic [7:0]                    key_code_i,
	input  logic                          cass_in_i,
	input  logic                          joy_up_i,
	input  logic                          joy_down_i,
	input  logic                          joy_left_i,
	input  logic                          joy_right_i,
	input  logic                          joy_fire_i,
	input  logic                          joy_arm_i,
	output logic                          cpu_clk_o,
	output logic [vz_bus_pkg::DATA_W-1:0] read_data_o,
	output logic [1:0]                    speaker_o,
	output logic                          cass_out_o,
	output logic                          vdg_ag_o,
	output logic                          vdg_css_o,
	output logic [2:0]                    vdg_gm_o
);

	logic                              latch_stb;
	logic [63:0]                       key_matrix;
	logic [9:0]                        key_ex;
	vz_bus_pkg::io_latch_u             io_latch;
	logic [vz_bus_pkg::DATA_W-1:0]     shrg_latch;
	logic [vz_bus_pkg::READ_SRC_W-1:0] read_src;

	vz_cpu_cycle u_cpu_cycle
	(
		.CLK50MHZ    (CLK50MHZ),
		.RESET_N     (RESET_N),
		.turbo_i     (turbo_i),
		.cpu_clk_o   (cpu_clk_o),
		.latch_stb_o (latch_stb)
	);

	vz_key_matrix u_key_matrix
	(
		.CLK50MHZ       (CLK50MHZ),
		.RESET_N        (RESET_N),
		.key_strobe_i   (key_strobe_i),
		.key_pressed_i  (key_pressed_i),
		.key_extended_i (key_extended_i),
		.key_code_i     (key_code_i),
		.key_matrix_o   (key_matrix),
		.key_ex_o       (key_ex)
	);

	vz_io_decode u_io_decode
	(
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.latch_stb_i  (latch_stb),
		.shrg_en_i    (shrg_en_i),
		.bus_addr_i   (bus_addr_i),
		.bus_data_i   (bus_data_i),
		.bus_mreq_i   (bus_mreq_i),
		.bus_iorq_i   (bus_iorq_i),
		.bus_rd_i     (bus_rd_i),
		.bus_wr_i     (bus_wr_i),
		.io_latch_o   (io_latch),
		.shrg_latch_o (shrg_latch),
		.read_src_o   (read_src)
	);

	vz_read_mux u_read_mux
	(
		.CLK50MHZ     (CLK50MHZ),
		.RESET_N      (RESET_N),
		.latch_stb_i  (latch_stb),
		.read_src_i   (read_src),
		.bus_addr_i   (bus_addr_i[7:0]),
		.key_matrix_i (key_matrix),
		.key_ex_i     (key_ex),
		.cass_in_i    (cass_in_i),
		.joy_up_i     (joy_up_i),
		.joy_down_i   (joy_down_i),
		.joy_left_i   (joy_left_i),
		.joy_right_i  (joy_right_i),
		.joy_fire_i   (joy_fire_i),
		.joy_arm_i    (joy_arm_i),
		.read_data_o  (read_data_o)
	);

	// Speaker pair in board order, bit 0 of the latch on top
	assign speaker_o  = {io_latch.bits.speaker_b, io_latch.bits.speaker_a};
	assign cass_out_o = io_latch.bits.cass_out;
	assign vdg_ag_o   = io_latch.bits.vdg_ag;
	assign vdg_css_o  = io_latch.bits.vdg_css;
	assign vdg_gm_o   = shrg_latch[4:2];   // MC6847 GM2..GM0

endmodule

/* rtl/vz_read_mux.sv */
`timescale 1ns/10ps

module vz_read_mux
(
	input  logic                              CLK50MHZ,
	input  logic                              RESET_N,
	input  logic                              latch_stb_i,
	input  logic [vz_bus_pkg::READ_SRC_W-1:0] read_src_i,
	input  logic [7:0]                        bus_addr_i,
	input  logic [63:0]                       key_matrix_i,
	input  logic [9:0]                        key_ex_i,
	input  logic                              cass_in_i,
	input  logic                              joy_up_i,
	input  logic                              joy_down_i,
	input  logic                              joy_left_i,
	input  logic                              joy_right_i,
	input  logic                              joy_fire_i,
	input  logic                              joy_arm_i,
	output logic [vz_bus_pkg::DATA_W-1:0]     read_data_o
);

	localparam int ROW_STRIDE = vz_kbd_pkg::KEY_COUNT / vz_kbd_pkg::KEY_ROWS;

	logic [vz_kbd_pkg::KEY_COUNT-1:0] eff;
	logic [vz_kbd_pkg::KEY_COLS-1:0]  kbd_col;
	logic                             ctrl_n;
	logic [7:0]                       kbd_byte;
	logic [7:0]                       joy_a;
	logic [7:0]                       joy_b;

	// Any cursor-type key also holds Ctrl down
	assign ctrl_n = key_ex_i[vz_kbd_pkg::EX_UP] & key_ex_i[vz_kbd_pkg::EX_LEFT] &
		key_ex_i[vz_kbd_pkg::EX_RIGHT] & key_ex_i[vz_kbd_pkg::EX_DOWN] &
		key_ex_i[vz_kbd_pkg::EX_ESC] & key_ex_i[vz_kbd_pkg::EX_BACKSPACE];

	always_comb
	begin
		eff = key_matrix_i;
		eff[vz_kbd_pkg::KEY_POS_PERIOD] &= key_ex_i[vz_kbd_pkg::EX_UP];
		eff[vz_kbd_pkg::KEY_POS_M]      &= key_ex_i[vz_kbd_pkg::EX_LEFT] &
			key_ex_i[vz_kbd_pkg::EX_BACKSPACE];
		eff[vz_kbd_pkg::KEY_POS_COMMA]  &= key_ex_i[vz_kbd_pkg::EX_RIGHT];
		eff[vz_kbd_pkg::KEY_POS_SPACE]  &= key_ex_i[vz_kbd_pkg::EX_DOWN];
		eff[vz_kbd_pkg::KEY_POS_MINUS]  &= key_ex_i[vz_kbd_pkg::EX_ESC];
		eff[vz_kbd_pkg::KEY_POS_LSHIFT] &= key_ex_i[vz_kbd_pkg::EX_RSHIFT];
		eff[vz_kbd_pkg::KEY_POS_CTRL]   &= ctrl_n;
	end

	// A low address bit selects its row, selected rows are ANDed per column
	always_comb
	begin
		kbd_col = '1;
		for (int r = 0; r < vz_kbd_pkg::KEY_ROWS; r++)
			for (int c = 0; c < vz_kbd_pkg::KEY_COLS; c++)
				if (!bus_addr_i[r] && !eff[r*ROW_STRIDE+c])
					kbd_col[c] = 1'b0;
	end

	assign kbd_byte = {1'b1, ~cass_in_i, kbd_col};
	assign joy_a    = {3'b111, ~joy_fire_i, ~joy_right_i, ~joy_left_i, ~joy_down_i, ~joy_up_i};
	assign joy_b    = {3'b111, ~joy_arm_i, 4'b1111};

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			read_data_o <= 8'hFF;
		else if (latch_stb_i)
		begin
			case (read_src_i)
				vz_bus_pkg::READ_SRC_KBD:   read_data_o <= kbd_byte;
				vz_bus_pkg::READ_SRC_JOY_A: read_data_o <= joy_a;
				vz_bus_pkg::READ_SRC_JOY_B: read_data_o <= joy_b;
				default:                    read_data_o <= 8'hFF;   // open bus
			endcase
		end
	end

endmodule

/* rtl/vz_io_decode.sv */
`timescale 1ns/10ps

module vz_io_decode
(
	input  logic                              CLK50MHZ,
	input  logic                              RESET_N,
	input  logic                              latch_stb_i,
	input  logic                              shrg_en_i,
	input  logic [vz_bus_pkg::ADDR_W-1:0]     bus_addr_i,
	input  logic [vz_bus_pkg::DATA_W-1:0]     bus_data_i,
	input  logic                              bus_mreq_i,
	input  logic                              bus_iorq_i,
	input  logic                              bus_rd_i,
	input  logic                              bus_wr_i,
	output vz_bus_pkg::io_latch_u             io_latch_o,
	output logic [vz_bus_pkg::DATA_W-1:0]     shrg_latch_o,
	output logic [vz_bus_pkg::READ_SRC_W-1:0] read_src_o
);

	logic       in_region;
	logic       mem_wr;
	logic       mem_rd;
	logic       io_wr;
	logic       io_rd;
	logic [7:0] port;

	assign in_region = (bus_addr_i[15:11] == vz_bus_pkg::IO_REGION_TAG);
	assign port      = bus_addr_i[7:0];   // Z80 I/O decodes only A7..A0

	assign mem_wr = bus_mreq_i & bus_wr_i & ~bus_rd_i;
	assign mem_rd = bus_mreq_i & bus_rd_i & ~bus_wr_i;
	assign io_wr  = bus_iorq_i & bus_wr_i & ~bus_rd_i;
	assign io_rd  = bus_iorq_i & bus_rd_i & ~bus_wr_i;

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			io_latch_o.raw <= '0;
			shrg_latch_o   <= vz_bus_pkg::SHRG_RESET;
		end
		else if (latch_stb_i)
		begin
			if (mem_wr && in_region)
				io_latch_o.raw <= bus_data_i;
			// SHRG port only exists when the board option is fitted
			if (io_wr && shrg_en_i && (port == vz_bus_pkg::PORT_SHRG))
				shrg_latch_o <= bus_data_i;
		end
	end

	// Read source, held steady by the bus for the whole CPU cycle
	always_comb
	begin
		if (mem_rd && in_region)
			read_src_o = vz_bus_pkg::READ_SRC_KBD;
		else if (io_rd && (port == vz_bus_pkg::PORT_JOY1_A))
			read_src_o = vz_bus_pkg::READ_SRC_JOY_A;
		else if (io_rd && (port == vz_bus_pkg::PORT_JOY1_B))
			read_src_o = vz_bus_pkg::READ_SRC_JOY_B;
		else
			read_src_o = vz_bus_pkg::READ_SRC_NONE;
	end

endmodule

/* rtl/vz_key_matrix.sv */
`timescale 1ns/10ps

module vz_key_matrix
(
	input  logic        CLK50MHZ,
	input  logic        RESET_N,
	input  logic        key_strobe_i,
	input  logic        key_pressed_i,
	input  logic        key_extended_i,
	input  logic [7:0]  key_code_i,
	output logic [63:0] key_matrix_o,
	output logic [9:0]  key_ex_o
);

	localparam int EX_BASE = vz_kbd_pkg::KEY_COUNT;
	localparam int SLOTS   = vz_kbd_pkg::KEY_COUNT + vz_kbd_pkg::KEY_EX_W;

	logic [SLOTS-1:0] keys_q;   // Active low, extension keys above the matrix
	int               slot;

	always_comb
	begin
		case (key_code_i)
			vz_kbd_pkg::SC_R:         slot = vz_kbd_pkg::KEY_POS_R;
			vz_kbd_pkg::SC_Q:         slot = vz_kbd_pkg::KEY_POS_Q;
			vz_kbd_pkg::SC_E:         slot = vz_kbd_pkg::KEY_POS_E;
			vz_kbd_pkg::SC_W:         slot = vz_kbd_pkg::KEY_POS_W;
			vz_kbd_pkg::SC_T:         slot = vz_kbd_pkg::KEY_POS_T;
			vz_kbd_pkg::SC_F:         slot = vz_kbd_pkg::KEY_POS_F;
			vz_kbd_pkg::SC_A:         slot = vz_kbd_pkg::KEY_POS_A;
			vz_kbd_pkg::SC_D:         slot = vz_kbd_pkg::KEY_POS_D;
			vz_kbd_pkg::SC_CTRL:      slot = vz_kbd_pkg::KEY_POS_CTRL;   // either side
			vz_kbd_pkg::SC_S:         slot = vz_kbd_pkg::KEY_POS_S;
			vz_kbd_pkg::SC_G:         slot = vz_kbd_pkg::KEY_POS_G;
			vz_kbd_pkg::SC_V:         slot = vz_kbd_pkg::KEY_POS_V;
			vz_kbd_pkg::SC_Z:         slot = vz_kbd_pkg::KEY_POS_Z;
			vz_kbd_pkg::SC_C:         slot = vz_kbd_pkg::KEY_POS_C;
			vz_kbd_pkg::SC_LSHIFT:    slot = vz_kbd_pkg::KEY_POS_LSHIFT;
			vz_kbd_pkg::SC_X:         slot = vz_kbd_pkg::KEY_POS_X;
			vz_kbd_pkg::SC_B:         slot = vz_kbd_pkg::KEY_POS_B;
			vz_kbd_pkg::SC_4:         slot = vz_kbd_pkg::KEY_POS_4;
			vz_kbd_pkg::SC_1:         slot = vz_kbd_pkg::KEY_POS_1;
			vz_kbd_pkg::SC_3:         slot = vz_kbd_pkg::KEY_POS_3;
			vz_kbd_pkg::SC_2:         slot = vz_kbd_pkg::KEY_POS_2;
			vz_kbd_pkg::SC_5:         slot = vz_kbd_pkg::KEY_POS_5;
			vz_kbd_pkg::SC_M:         slot = vz_kbd_pkg::KEY_POS_M;
			vz_kbd_pkg::SC_SPACE:     slot = vz_kbd_pkg::KEY_POS_SPACE;
			vz_kbd_pkg::SC_COMMA:     slot = vz_kbd_pkg::KEY_POS_COMMA;
			vz_kbd_pkg::SC_PERIOD:    slot = vz_kbd_pkg::KEY_POS_PERIOD;
			vz_kbd_pkg::SC_N:         slot = vz_kbd_pkg::KEY_POS_N;
			vz_kbd_pkg::SC_7:         slot = vz_kbd_pkg::KEY_POS_7;
			vz_kbd_pkg::SC_0:         slot = vz_kbd_pkg::KEY_POS_0;
			vz_kbd_pkg::SC_8:         slot = vz_kbd_pkg::KEY_POS_8;
			vz_kbd_pkg::SC_MINUS:     slot = vz_kbd_pkg::KEY_POS_MINUS;
			vz_kbd_pkg::SC_9:         slot = vz_kbd_pkg::KEY_POS_9;
			vz_kbd_pkg::SC_6:         slot = vz_kbd_pkg::KEY_POS_6;
			vz_kbd_pkg::SC_U:         slot = vz_kbd_pkg::KEY_POS_U;
			vz_kbd_pkg::SC_P:         slot = vz_kbd_pkg::KEY_POS_P;
			vz_kbd_pkg::SC_I:         slot = vz_kbd_pkg::KEY_POS_I;
			vz_kbd_pkg::SC_RETURN:    slot = vz_kbd_pkg::KEY_POS_RETURN;
			vz_kbd_pkg::SC_O:         slot = vz_kbd_pkg::KEY_POS_O;
			vz_kbd_pkg::SC_Y:         slot = vz_kbd_pkg::KEY_POS_Y;
			vz_kbd_pkg::SC_J:         slot = vz_kbd_pkg::KEY_POS_J;
			vz_kbd_pkg::SC_SEMI:      slot = vz_kbd_pkg::KEY_POS_SEMI;
			vz_kbd_pkg::SC_K:         slot = vz_kbd_pkg::KEY_POS_K;
			vz_kbd_pkg::SC_QUOTE:     slot = vz_kbd_pkg::KEY_POS_QUOTE;
			vz_kbd_pkg::SC_L:         slot = vz_kbd_pkg::KEY_POS_L;
			vz_kbd_pkg::SC_H:         slot = vz_kbd_pkg::KEY_POS_H;
			vz_kbd_pkg::SC_RSHIFT:    slot = EX_BASE + vz_kbd_pkg::EX_RSHIFT;
			vz_kbd_pkg::SC_ESC:       slot = EX_BASE + vz_kbd_pkg::EX_ESC;
			vz_kbd_pkg::SC_UP:        slot = EX_BASE + vz_kbd_pkg::EX_UP;
			vz_kbd_pkg::SC_LEFT:      slot = EX_BASE + vz_kbd_pkg::EX_LEFT;
			vz_kbd_pkg::SC_RIGHT:     slot = EX_BASE + vz_kbd_pkg::EX_RIGHT;
			vz_kbd_pkg::SC_DOWN:      slot = EX_BASE + vz_kbd_pkg::EX_DOWN;
			vz_kbd_pkg::SC_BACKSPACE: slot = EX_BASE + vz_kbd_pkg::EX_BACKSPACE;
			// Left Alt is repeat, right Alt (E0 prefix) is line feed
			vz_kbd_pkg::SC_EXT_ALT:   slot = EX_BASE + (key_extended_i ?
				vz_kbd_pkg::EX_LF : vz_kbd_pkg::EX_REPEAT);
			default:                  slot = -1;
		endcase
	end

	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
			keys_q <= '1;
		else if (key_strobe_i && (slot >= 0))
			keys_q[slot] <= ~key_pressed_i;
	end

	assign key_matrix_o = keys_q[EX_BASE-1:0];
	assign key_ex_o     = keys_q[SLOTS-1:EX_BASE];

endmodule

/* rtl/vz_cpu_cycle.sv */
`timescale 1ns/10ps

module vz_cpu_cycle
(
	input  logic CLK50MHZ,
	input  logic RESET_N,
	input  logic turbo_i,
	output logic cpu_clk_o,
	output logic latch_stb_o
);

	logic [3:0] cnt_q;
	logic [3:0] cnt_nxt;
	logic       wrap;

	// Turbo is only looked at on count 3, a change mid-cycle waits for it
	assign wrap = (cnt_q == vz_bus_pkg::CYC_NORMAL_LAST) ||
		((cnt_q == vz_bus_pkg::CYC_TURBO_LAST) && turbo_i);

	assign cnt_nxt = wrap ? 4'd0 : cnt_q + 4'd1;

	// Both pulses decode the next count, so they line up with counts 0 and 1
	always_ff @(posedge CLK50MHZ or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			cnt_q       <= vz_bus_pkg::CYC_NORMAL_LAST;   // first edge starts a fresh cycle
			cpu_clk_o   <= 1'b0;
			latch_stb_o <= 1'b0;
		end
		else
		begin
			cnt_q       <= cnt_nxt;
			cpu_clk_o   <= (cnt_nxt == 4'd0);
			latch_stb_o <= (cnt_nxt == vz_bus_pkg::CYC_LATCH);
		end
	end

endmodule

/* rtl/vz_kbd_pkg.sv */
package vz_kbd_pkg;

	localparam int KEY_ROWS  = 8;
	localparam int KEY_COLS  = 6;
	localparam int KEY_COUNT = 64;   // 8 per row, top two columns unused
	localparam int KEY_EX_W  = 10;

	// PS/2 set 2 codes, listed by matrix row A0..A7
	localparam logic [7:0] SC_R = 8'h2D, SC_Q = 8'h15, SC_E = 8'h24, SC_W = 8'h1D, SC_T = 8'h2C;
	localparam logic [7:0] SC_F = 8'h2B, SC_A = 8'h1C, SC_D = 8'h23, SC_CTRL = 8'h14;
	localparam logic [7:0] SC_S = 8'h1B, SC_G = 8'h34;
	localparam logic [7:0] SC_V = 8'h2A, SC_Z = 8'h1A, SC_C = 8'h21, SC_LSHIFT = 8'h12;
	localparam logic [7:0] SC_X = 8'h22, SC_B = 8'h32;
	localparam logic [7:0] SC_4 = 8'h25, SC_1 = 8'h16, SC_3 = 8'h26, SC_2 = 8'h1E, SC_5 = 8'h2E;
	localparam logic [7:0] SC_M = 8'h3A, SC_SPACE = 8'h29, SC_COMMA = 8'h41;
	localparam logic [7:0] SC_PERIOD = 8'h49, SC_N = 8'h31;
	localparam logic [7:0] SC_7 = 8'h3D, SC_0 = 8'h45, SC_8 = 8'h3E, SC_MINUS = 8'h4E;
	localparam logic [7:0] SC_9 = 8'h46, SC_6 = 8'h36;
	localparam logic [7:0] SC_U = 8'h3C, SC_P = 8'h4D, SC_I = 8'h43, SC_RETURN = 8'h5A;
	localparam logic [7:0] SC_O = 8'h44, SC_Y = 8'h35;
	localparam logic [7:0] SC_J = 8'h3B, SC_SEMI = 8'h4C, SC_K = 8'h42, SC_QUOTE = 8'h52;
	localparam logic [7:0] SC_L = 8'h4B, SC_H = 8'h33;

	// Keys with no matrix position of their own
	localparam logic [7:0] SC_RSHIFT = 8'h59, SC_EXT_ALT = 8'h11, SC_ESC = 8'h76;
	localparam logic [7:0] SC_UP = 8'h75, SC_LEFT = 8'h6B, SC_RIGHT = 8'h74, SC_DOWN = 8'h72;
	localparam logic [7:0] SC_BACKSPACE = 8'h66;

	// Matrix index is row * 8 + column
	localparam int KEY_POS_R = 5, KEY_POS_Q = 4, KEY_POS_E = 3, KEY_POS_W = 1, KEY_POS_T = 0;
	localparam int KEY_POS_F = 13, KEY_POS_A = 12, KEY_POS_D = 11, KEY_POS_CTRL = 10;
	localparam int KEY_POS_S = 9, KEY_POS_G = 8;
	localparam int KEY_POS_V = 21, KEY_POS_Z = 20, KEY_POS_C = 19, KEY_POS_LSHIFT = 18;
	localparam int KEY_POS_X = 17, KEY_POS_B = 16;
	localparam int KEY_POS_4 = 29, KEY_POS_1 = 28, KEY_POS_3 = 27, KEY_POS_2 = 25, KEY_POS_5 = 24;
	localparam int KEY_POS_M = 37, KEY_POS_SPACE = 36, KEY_POS_COMMA = 35;
	localparam int KEY_POS_PERIOD = 33, KEY_POS_N = 32;
	localparam int KEY_POS_7 = 45, KEY_POS_0 = 44, KEY_POS_8 = 43, KEY_POS_MINUS = 42;
	localparam int KEY_POS_9 = 41, KEY_POS_6 = 40;
	localparam int KEY_POS_U = 53, KEY_POS_P = 52, KEY_POS_I = 51, KEY_POS_RETURN = 50;
	localparam int KEY_POS_O = 49, KEY_POS_Y = 48;
	localparam int KEY_POS_J = 61, KEY_POS_SEMI = 60, KEY_POS_K = 59;
	localparam int KEY_POS_QUOTE = 58;   // lands on the colon key
	localparam int KEY_POS_L = 57, KEY_POS_H = 56;

	localparam int EX_RSHIFT = 0, EX_REPEAT = 1, EX_LF = 2, EX_ESC = 3, EX_UP = 4;
	localparam int EX_LEFT = 5, EX_RIGHT = 6, EX_DOWN = 7, EX_BACKSPACE = 8;

endpackage

/* rtl/vz_bus_pkg.sv */
package vz_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Upper address bits of 6800h-6FFFh, A10..A8 are don't care
	localparam logic [4:0] IO_REGION_TAG = 5'b01101;

	// I/O ports, low address byte only
	localparam logic [7:0] PORT_SHRG   = 8'h20;
	localparam logic [7:0] PORT_JOY1_A = 8'h2E;
	localparam logic [7:0] PORT_JOY1_B = 8'h2D;

	localparam logic [3:0] CYC_NORMAL_LAST = 4'd13;   // 14 clocks per CPU cycle
	localparam logic [3:0] CYC_TURBO_LAST  = 4'd3;    // 4 clocks in turbo
	localparam logic [3:0] CYC_LATCH       = 4'd1;

	// GM = 010 after reset
	localparam logic [7:0] SHRG_RESET = 8'h08;

	localparam int READ_SRC_W = 2;
	localparam logic [READ_SRC_W-1:0] READ_SRC_NONE  = 2'd0;
	localparam logic [READ_SRC_W-1:0] READ_SRC_KBD   = 2'd1;
	localparam logic [READ_SRC_W-1:0] READ_SRC_JOY_A = 2'd2;
	localparam logic [READ_SRC_W-1:0] READ_SRC_JOY_B = 2'd3;

	// Write latch at 6800h, seen as the stored byte or as its control bits
	typedef union packed
	{
		logic [DATA_W-1:0] raw;
		struct packed
		{
			logic [1:0] unused_hi;
			logic       speaker_a;
			logic       vdg_css;
			logic       vdg_ag;
			logic       cass_out;
			logic       unused_1;
			logic       speaker_b;
		} bits;
	} io_latch_u;

endpackage
